//--- verilog/scope_pkg.sv
package scope_pkg;

  // AXI4-Lite register port
  localparam int AXI_ADDR_W = 4;
  localparam int AXI_DATA_W = 32;

  typedef logic [23:0] rgb_t;    // red in [23:16], blue in [7:0]
  typedef logic [11:0] coord_t;  // pixel column or row
  typedef logic [7:0]  sample_t; // raw adc code

  // gain register layout
  localparam int GAIN_SHIFT_W = 2; // shift amount in gain[1:0]
  localparam int GAIN_UP_BIT  = 2; // 1 = shift left (zoom in)

  typedef logic [GAIN_UP_BIT:0] gain_t;

  // register byte offsets
  localparam logic [AXI_ADDR_W-1:0] REG_WAVE_COLOR = 4'h0;
  localparam logic [AXI_ADDR_W-1:0] REG_TRIG_ROW   = 4'h4;
  localparam logic [AXI_ADDR_W-1:0] REG_GAIN       = 4'h8;
  localparam logic [AXI_ADDR_W-1:0] REG_ID         = 4'hC;

  localparam logic [AXI_DATA_W-1:0] SCOPE_ID = 32'h5c09_e001;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  localparam rgb_t WAVE_COLOR_RST = 24'hff0000; // red trace after reset
  localparam rgb_t TRIG_COLOR     = 24'h0000ff; // blue trigger line

endpackage

//--- verilog/scope_if.sv
`timescale 1ns/100ps

interface scope_cfg_if;
  import scope_pkg::*;

  rgb_t   wave_color; // trace colour
  coord_t trig_row;   // row of trigger line
  gain_t  gain;       // direction bit + shift amount

  modport cfg (
    output wave_color,
    output trig_row,
    output gain
  );

  modport user (
    input wave_color,
    input trig_row,
    input gain
  );
endinterface

interface video_pos_if;
  import scope_pkg::*;

  logic   hs;
  logic   vs;
  logic   de;
  rgb_t   data;
  coord_t x; // column of this pixel
  coord_t y; // row of this pixel

  modport src (output hs, output vs, output de, output data, output x, output y);
  modport snk (input hs, input vs, input de, input data, input x, input y);
endinterface

//--- verilog/sample_ram.sv
`timescale 1ns/100ps

module sample_ram #(
  parameter int ADDR_W = 10
) (
  input  logic                  i_wr_clk,
  input  logic                  i_wr_en,
  input  logic [ADDR_W-1:0]     i_wr_addr,
  input  scope_pkg::sample_t    i_wr_data,
  input  logic                  pclk,
  input  logic [ADDR_W-1:0]     i_rd_addr,
  output scope_pkg::sample_t    o_rd_data
);

  localparam int DEPTH = 1 << ADDR_W;

  logic [7:0] mem [DEPTH];

  // adc side
  always_ff @(posedge i_wr_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // display side, one cycle read
  always_ff @(posedge pclk) begin
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

//--- verilog/scope_cfg_axil.sv
`timescale 1ns/100ps

module scope_cfg_axil (
  input  logic                               pclk,
  input  logic                               rst_n,
  input  logic [scope_pkg::AXI_ADDR_W-1:0]   i_awaddr,
  input  logic                               i_awvalid,
  output logic                               o_awready,
  input  logic [scope_pkg::AXI_DATA_W-1:0]   i_wdata,
  input  logic [scope_pkg::AXI_DATA_W/8-1:0] i_wstrb,
  input  logic                               i_wvalid,
  output logic                               o_wready,
  output logic [1:0]                         o_bresp,
  output logic                               o_bvalid,
  input  logic                               i_bready,
  input  logic [scope_pkg::AXI_ADDR_W-1:0]   i_araddr,
  input  logic                               i_arvalid,
  output logic                               o_arready,
  output logic [scope_pkg::AXI_DATA_W-1:0]   o_rdata,
  output logic [1:0]                         o_rresp,
  output logic                               o_rvalid,
  input  logic                               i_rready,
  scope_cfg_if.cfg                           cfg
);
  import scope_pkg::*;

  localparam int STRB_W = AXI_DATA_W / 8;

  rgb_t   r_wave_color;
  coord_t r_trig_row;
  gain_t  r_gain;

  logic                  wr_acc;
  logic                  rd_acc;
  logic                  wr_known;
  logic                  rd_known;
  logic [AXI_DATA_W-1:0] rd_word;
  logic [AXI_DATA_W-1:0] wave_merged;
  logic [AXI_DATA_W-1:0] trig_merged;
  logic [AXI_DATA_W-1:0] gain_merged;

  // byte lanes with strobe set take the new data
  function automatic logic [AXI_DATA_W-1:0] merge_strb(
    input logic [AXI_DATA_W-1:0] old_w,
    input logic [AXI_DATA_W-1:0] new_w,
    input logic [STRB_W-1:0]     strb
  );
    logic [AXI_DATA_W-1:0] res;
    res = old_w;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  assign wr_acc    = i_awvalid && i_wvalid && !o_bvalid; // no response pending
  assign rd_acc    = i_arvalid && !o_rvalid;
  assign o_awready = wr_acc;
  assign o_wready  = wr_acc;
  assign o_arready = rd_acc;

  assign wave_merged = merge_strb(AXI_DATA_W'(r_wave_color), i_wdata, i_wstrb);
  assign trig_merged = merge_strb(AXI_DATA_W'(r_trig_row), i_wdata, i_wstrb);
  assign gain_merged = merge_strb(AXI_DATA_W'(r_gain), i_wdata, i_wstrb);

  assign wr_known = (i_awaddr == REG_WAVE_COLOR) || (i_awaddr == REG_TRIG_ROW) ||
                    (i_awaddr == REG_GAIN) || (i_awaddr == REG_ID); // id is read-only

  always_comb begin
    rd_word  = '0;
    rd_known = 1'b1;
    case (i_araddr)
      REG_WAVE_COLOR: rd_word = AXI_DATA_W'(r_wave_color);
      REG_TRIG_ROW:   rd_word = AXI_DATA_W'(r_trig_row);
      REG_GAIN:       rd_word = AXI_DATA_W'(r_gain);
      REG_ID:         rd_word = SCOPE_ID;
      default:        rd_known = 1'b0;
    endcase
  end

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      r_wave_color <= WAVE_COLOR_RST;
      r_trig_row   <= '0;
      r_gain       <= '0;
      o_bvalid     <= 1'b0;
      o_rvalid     <= 1'b0;
    end else begin
      if (wr_acc) begin
        case (i_awaddr)
          REG_WAVE_COLOR: r_wave_color <= rgb_t'(wave_merged);
          REG_TRIG_ROW:   r_trig_row   <= coord_t'(trig_merged);
          REG_GAIN:       r_gain       <= gain_t'(gain_merged);
          default:        ;
        endcase
      end
      if (wr_acc) o_bvalid <= 1'b1;
      else if (i_bready) o_bvalid <= 1'b0;
      if (rd_acc) o_rvalid <= 1'b1;
      else if (i_rready) o_rvalid <= 1'b0;
    end
  end

  // response payload, only sampled while valid
  always_ff @(posedge pclk) begin
    if (wr_acc) o_bresp <= wr_known ? RESP_OKAY : RESP_SLVERR;
    if (rd_acc) begin
      o_rdata <= rd_word;
      o_rresp <= rd_known ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign cfg.wave_color = r_wave_color;
  assign cfg.trig_row   = r_trig_row;
  assign cfg.gain       = r_gain;

endmodule

//--- verilog/pixel_position.sv
`timescale 1ns/100ps

module pixel_position (
  input  logic            pclk,
  input  logic            rst_n,
  input  logic            i_hs,
  input  logic            i_vs,
  input  logic            i_de,
  input  scope_pkg::rgb_t i_data,
  video_pos_if.src        vo
);
  import scope_pkg::*;

  coord_t x_cnt; // column of the next active pixel
  coord_t y_cnt; // current active line

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      vo.hs <= 1'b0;
      vo.vs <= 1'b0;
      vo.de <= 1'b0;
      vo.x  <= '0;
      vo.y  <= '0;
      x_cnt <= '0;
      y_cnt <= '0;
    end else begin
      vo.hs <= i_hs;
      vo.vs <= i_vs;
      vo.de <= i_de;
      if (i_de) begin
        vo.x  <= x_cnt;
        vo.y  <= y_cnt;
        x_cnt <= x_cnt + 1'b1;
      end else begin
        x_cnt <= '0; // restart with the next line
      end

      // vs wins over the line step
      if (i_vs) begin
        y_cnt <= '0;
      end else if (vo.de && !i_de) begin
        y_cnt <= y_cnt + 1'b1; // falling edge of de
      end
    end
  end

  always_ff @(posedge pclk) begin
    vo.data <= i_data;
  end

endmodule

//--- verilog/wave_overlay.sv
`timescale 1ns/100ps

module wave_overlay #(
  parameter int WIN_X0    = 442,
  parameter int WIN_Y0    = 9,
  parameter int WIN_Y1    = 1075,
  parameter int TRACE_MID = 541,
  parameter int ADDR_W    = 10
) (
  input  logic               pclk,
  input  logic               rst_n,
  video_pos_if.snk           vi,
  scope_cfg_if.user          cfg,
  output logic [ADDR_W-1:0]  o_rd_addr,
  input  scope_pkg::sample_t i_rd_data,
  output logic               o_hs,
  output logic               o_vs,
  output logic               o_de,
  output scope_pkg::rgb_t    o_data,
  output logic               o_frame_done
);
  import scope_pkg::*;

  localparam coord_t X_FIRST = coord_t'(WIN_X0);
  localparam coord_t X_LAST  = coord_t'(WIN_X0 + (1 << ADDR_W) - 1);
  localparam coord_t Y_FIRST = coord_t'(WIN_Y0);
  localparam coord_t Y_LAST  = coord_t'(WIN_Y1);
  localparam logic signed [12:0] MID_S = 13'(TRACE_MID);
  localparam logic signed [12:0] Y0_S  = 13'(WIN_Y0);
  localparam logic signed [12:0] Y1_S  = 13'(WIN_Y1);

  logic   in_win;
  logic   at_first;
  logic   at_last;
  coord_t col_off;

  // stage 1 lines up with the ram data
  logic   hs_d, vs_d, de_d;
  logic   win_d, first_d, last_d;
  rgb_t   pix_d;
  coord_t y_d;
  coord_t prev_row; // trace row of the column before

  sample_t                  level;
  logic signed [12:0]       diff;
  logic signed [12:0]       scaled;
  logic signed [12:0]       row_s;
  logic [GAIN_SHIFT_W-1:0]  shamt;
  coord_t                   cur_row;
  coord_t                   prev_sel;
  coord_t                   row_lo;
  coord_t                   row_hi;
  rgb_t                     pix_sel;

  assign in_win = vi.de && (vi.x >= X_FIRST) && (vi.x <= X_LAST) &&
                  (vi.y >= Y_FIRST) && (vi.y <= Y_LAST);
  assign at_first  = (vi.x == X_FIRST);
  assign at_last   = in_win && (vi.x == X_LAST) && (vi.y == Y_LAST);
  assign col_off   = vi.x - X_FIRST;
  assign o_rd_addr = col_off[ADDR_W-1:0]; // column offset in window

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      hs_d    <= 1'b0;
      vs_d    <= 1'b0;
      de_d    <= 1'b0;
      win_d   <= 1'b0;
      first_d <= 1'b0;
      last_d  <= 1'b0;
    end else begin
      hs_d    <= vi.hs;
      vs_d    <= vi.vs;
      de_d    <= vi.de;
      win_d   <= in_win;
      first_d <= at_first;
      last_d  <= at_last;
    end
  end

  always_ff @(posedge pclk) begin
    pix_d <= vi.data;
    y_d   <= vi.y;
  end

  // sample to screen row; high codes sit near the top
  always_comb begin
    level = 8'd255 - i_rd_data;
    diff  = $signed({5'b0, level}) - 13'sd128;
    shamt = cfg.gain[GAIN_SHIFT_W-1:0];
    if (cfg.gain[GAIN_UP_BIT]) scaled = diff <<< shamt;
    else scaled = diff >>> shamt;
    row_s = MID_S + scaled;
    if (row_s < Y0_S) cur_row = Y_FIRST; // clamp to window
    else if (row_s > Y1_S) cur_row = Y_LAST;
    else cur_row = coord_t'(row_s);
  end

  assign prev_sel = first_d ? cur_row : prev_row; // no left neighbour at column 0
  assign row_lo   = (prev_sel < cur_row) ? prev_sel : cur_row;
  assign row_hi   = (prev_sel < cur_row) ? cur_row : prev_sel;

  always_comb begin
    if (win_d && (y_d >= row_lo) && (y_d <= row_hi)) pix_sel = cfg.wave_color;
    else if (win_d && (y_d == cfg.trig_row)) pix_sel = TRIG_COLOR;
    else pix_sel = pix_d;
  end

  always_ff @(posedge pclk) begin
    if (win_d) prev_row <= cur_row;
  end

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      o_hs         <= 1'b0;
      o_vs         <= 1'b0;
      o_de         <= 1'b0;
      o_data       <= '0;
      o_frame_done <= 1'b0;
    end else begin
      o_hs         <= hs_d;
      o_vs         <= vs_d;
      o_de         <= de_d;
      o_data       <= pix_sel;
      o_frame_done <= last_d; // last window pixel of the frame
    end
  end

endmodule

//--- verilog/scope_display_top.sv
`timescale 1ns/100ps

module scope_display_top #(
  parameter int WIN_X0    = 442,
  parameter int WIN_Y0    = 9,
  parameter int WIN_Y1    = 1075,
  parameter int TRACE_MID = 541,
  parameter int ADDR_W    = 10
) (
  input  logic                               pclk,
  input  logic                               rst_n,
  input  logic [scope_pkg::AXI_ADDR_W-1:0]   i_awaddr,
  input  logic                               i_awvalid,
  output logic                               o_awready,
  input  logic [scope_pkg::AXI_DATA_W-1:0]   i_wdata,
  input  logic [scope_pkg::AXI_DATA_W/8-1:0] i_wstrb,
  input  logic                               i_wvalid,
  output logic                               o_wready,
  output logic [1:0]                         o_bresp,
  output logic                               o_bvalid,
  input  logic                               i_bready,
  input  logic [scope_pkg::AXI_ADDR_W-1:0]   i_araddr,
  input  logic                               i_arvalid,
  output logic                               o_arready,
  output logic [scope_pkg::AXI_DATA_W-1:0]   o_rdata,
  output logic [1:0]                         o_rresp,
  output logic                               o_rvalid,
  input  logic                               i_rready,
  input  logic                               i_ad_clk,
  input  logic                               i_ad_wr,
  input  logic [ADDR_W-1:0]                  i_ad_addr,
  input  scope_pkg::sample_t                 i_ad_data,
  input  logic                               i_hs,
  input  logic                               i_vs,
  input  logic                               i_de,
  input  scope_pkg::rgb_t                    i_data,
  output logic                               o_hs,
  output logic                               o_vs,
  output logic                               o_de,
  output scope_pkg::rgb_t                    o_data,
  output logic                               o_frame_done
);
  import scope_pkg::*;

  scope_cfg_if cfg_if ();
  video_pos_if pos_if ();

  logic [ADDR_W-1:0] rd_addr;
  sample_t           rd_data;

  scope_cfg_axil cfg0 (
    .pclk, .rst_n,
    .i_awaddr, .i_awvalid, .o_awready, .i_wdata, .i_wstrb, .i_wvalid, .o_wready,
    .o_bresp, .o_bvalid, .i_bready,
    .i_araddr, .i_arvalid, .o_arready, .o_rdata, .o_rresp, .o_rvalid, .i_rready,
    .cfg (cfg_if.cfg)
  );

  pixel_position pos0 (
    .pclk, .rst_n, .i_hs, .i_vs, .i_de, .i_data,
    .vo (pos_if.src)
  );

  sample_ram #(.ADDR_W(ADDR_W)) ram0 (
    .i_wr_clk  (i_ad_clk),
    .i_wr_en   (i_ad_wr),
    .i_wr_addr (i_ad_addr),
    .i_wr_data (i_ad_data),
    .pclk      (pclk),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data)
  );

  wave_overlay #(
    .WIN_X0(WIN_X0), .WIN_Y0(WIN_Y0), .WIN_Y1(WIN_Y1),
    .TRACE_MID(TRACE_MID), .ADDR_W(ADDR_W)
  ) ovl0 (
    .pclk, .rst_n,
    .vi        (pos_if.snk),
    .cfg       (cfg_if.user),
    .o_rd_addr (rd_addr),
    .i_rd_data (rd_data),
    .o_hs, .o_vs, .o_de, .o_data, .o_frame_done
  );

endmodule

//--- test/tb_scope.sv
`timescale 1ns/100ps

module tb_scope;
  import scope_pkg::*;

  localparam int WIN_X0      = 8;
  localparam int ADDR_W      = 5;
  localparam int WIN_Y0      = 4;
  localparam int WIN_Y1      = 35;
  localparam int TRACE_MID   = 20;
  localparam int WIN_W       = 1 << ADDR_W;
  localparam int H_TOTAL     = 80;
  localparam int V_TOTAL     = 48;
  localparam int H_ACTIVE    = 64;
  localparam int V_ACTIVE    = 40;
  localparam int CYCLE_LIMIT = 8 * H_TOTAL * V_TOTAL + 2000;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  typedef struct packed {
    logic v;     // compare this entry
    logic hs;
    logic vs;
    logic de;
    logic fd;
    rgb_t data;
  } exp_t;

  logic                    pclk;
  logic                    rst_n;
  logic                    i_ad_clk;
  logic [AXI_ADDR_W-1:0]   i_awaddr;
  logic                    i_awvalid;
  logic                    o_awready;
  logic [AXI_DATA_W-1:0]   i_wdata;
  logic [AXI_DATA_W/8-1:0] i_wstrb;
  logic                    i_wvalid;
  logic                    o_wready;
  logic [1:0]              o_bresp;
  logic                    o_bvalid;
  logic                    i_bready;
  logic [AXI_ADDR_W-1:0]   i_araddr;
  logic                    i_arvalid;
  logic                    o_arready;
  logic [AXI_DATA_W-1:0]   o_rdata;
  logic [1:0]              o_rresp;
  logic                    o_rvalid;
  logic                    i_rready;
  logic                    i_ad_wr;
  logic [ADDR_W-1:0]       i_ad_addr;
  sample_t                 i_ad_data;
  logic                    i_hs;
  logic                    i_vs;
  logic                    i_de;
  rgb_t                    i_data;
  logic                    o_hs;
  logic                    o_vs;
  logic                    o_de;
  rgb_t                    o_data;
  logic                    o_frame_done;

  logic [31:0] lfsr = 32'hc3aa30a4;
  logic [31:0] sh_wave = 32'h00ff_0000; // register shadows
  logic [31:0] sh_trig = '0;
  logic [31:0] sh_gain = '0;
  logic [7:0]  samp_sh [WIN_W];
  int          tb_x = 0; // column and row of the driven pixel
  int          tb_y = 0;
  exp_t        exp_q [$];
  int          n_errs = 0;
  int          test_err_base = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;
  int          fd_cnt = 0;
  int          blue_cnt = 0;
  int          cyc = 0;

  scope_display_top #(
    .WIN_X0(WIN_X0), .WIN_Y0(WIN_Y0), .WIN_Y1(WIN_Y1),
    .TRACE_MID(TRACE_MID), .ADDR_W(ADDR_W)
  ) dut0 (.*);

  initial begin
    pclk = 1'b0;
    forever #20 pclk = ~pclk;
  end

  initial begin
    i_ad_clk = 1'b0;
    forever #28 i_ad_clk = ~i_ad_clk;
  end

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ LFSR_TAPS;
      v = {v[30:0], b};
    end
    return v;
  endfunction

  function automatic logic [31:0] apply_strobes(input logic [31:0] old_v,
                                                input logic [31:0] new_v,
                                                input logic [3:0]  strb);
    logic [31:0] keep;
    keep = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_v & ~keep) | (new_v & keep);
  endfunction

  function automatic int trace_row(input logic [7:0] s);
    int d;
    int r;
    d = (255 - int'(s)) - 128;
    if (sh_gain[2]) d = d * (1 << sh_gain[1:0]);
    else d = d >>> sh_gain[1:0]; // floor division
    r = TRACE_MID + d;
    if (r < WIN_Y0) r = WIN_Y0;
    if (r > WIN_Y1) r = WIN_Y1;
    return r;
  endfunction

  function automatic logic in_window(input logic de, input int x, input int y);
    return de && (x >= WIN_X0) && (x < WIN_X0 + WIN_W) && (y >= WIN_Y0) && (y <= WIN_Y1);
  endfunction

  function automatic int prev_row(input int x);
    if (x <= WIN_X0) return trace_row(samp_sh[0]); // first column joins itself
    return trace_row(samp_sh[x - WIN_X0 - 1]);
  endfunction

  function automatic rgb_t expect_pixel(input rgb_t pix, input logic de, input int x,
                                        input int y, input int prev);
    int cur;
    int lo;
    int hi;
    if (!in_window(de, x, y)) return pix;
    cur = trace_row(samp_sh[x - WIN_X0]);
    lo  = (prev < cur) ? prev : cur;
    hi  = (prev < cur) ? cur : prev;
    if (y >= lo && y <= hi) return sh_wave[23:0];
    if (y == int'(sh_trig[11:0])) return 24'h0000ff;
    return pix;
  endfunction

  // outputs lag the driven inputs by three cycles
  always @(negedge pclk) begin : compare_proc
    exp_t e;
    int   prev;
    prev = 0;
    if (in_window(i_de, tb_x, tb_y)) prev = prev_row(tb_x);
    e.v    = rst_n;
    e.hs   = i_hs;
    e.vs   = i_vs;
    e.de   = i_de;
    e.fd   = in_window(i_de, tb_x, tb_y) && (tb_x == WIN_X0 + WIN_W - 1) && (tb_y == WIN_Y1);
    e.data = expect_pixel(i_data, i_de, tb_x, tb_y, prev);
    exp_q.push_back(e);
    if (o_frame_done === 1'b1) fd_cnt++;
    if (exp_q.size() > 3) begin
      e = exp_q.pop_front();
      if (e.v) begin
        if (o_data !== e.data) begin
          $display("CHECK FAILED o_data: expected %h, got %h", e.data, o_data);
          n_errs++;
        end
        if (o_de !== e.de) begin
          $display("CHECK FAILED o_de: expected %h, got %h", e.de, o_de);
          n_errs++;
        end
        if (o_hs !== e.hs) begin
          $display("CHECK FAILED o_hs: expected %h, got %h", e.hs, o_hs);
          n_errs++;
        end
        if (o_vs !== e.vs) begin
          $display("CHECK FAILED o_vs: expected %h, got %h", e.vs, o_vs);
          n_errs++;
        end
        if (o_frame_done !== e.fd) begin
          $display("CHECK FAILED o_frame_done: expected %h, got %h", e.fd, o_frame_done);
          n_errs++;
        end
        if (e.data === 24'h0000ff && o_data === e.data) blue_cnt++;
      end
    end
  end

  always @(posedge pclk) begin
    cyc++;
    if (cyc >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    @(posedge pclk);
    i_awaddr  <= addr;
    i_wdata   <= data;
    i_wstrb   <= strb;
    i_awvalid <= 1'b1;
    i_wvalid  <= 1'b1;
    @(negedge pclk);
    while (!o_awready) @(negedge pclk);
    if (o_wready !== 1'b1) begin
      $display("CHECK FAILED o_wready: expected %h, got %h", 1'b1, o_wready);
      n_errs++;
    end
    @(posedge pclk); // accepted on this edge
    i_awvalid <= 1'b0;
    i_wvalid  <= 1'b0;
    @(negedge pclk);
    while (!o_bvalid) @(negedge pclk);
    resp = o_bresp;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge pclk);
    i_araddr  <= addr;
    i_arvalid <= 1'b1;
    @(negedge pclk);
    while (!o_arready) @(negedge pclk);
    @(posedge pclk);
    i_arvalid <= 1'b0;
    @(negedge pclk);
    while (!o_rvalid) @(negedge pclk);
    data = o_rdata;
    resp = o_rresp;
  endtask

  task automatic reg_write(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [1:0] resp;
    axi_write(addr, data, strb, resp);
    if (resp !== 2'b00) begin
      $display("CHECK FAILED o_bresp: expected %h, got %h", 2'b00, resp);
      n_errs++;
    end
    case (addr)
      REG_WAVE_COLOR: sh_wave = apply_strobes(sh_wave, data, strb) & 32'h00ff_ffff;
      REG_TRIG_ROW:   sh_trig = apply_strobes(sh_trig, data, strb) & 32'h0000_0fff;
      REG_GAIN:       sh_gain = apply_strobes(sh_gain, data, strb) & 32'h0000_0007;
      default:        ;
    endcase
  endtask

  task automatic reg_check(input logic [3:0] addr, input logic [31:0] exp_v);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    if (resp !== 2'b00) begin
      $display("CHECK FAILED o_rresp: expected %h, got %h", 2'b00, resp);
      n_errs++;
    end
    if (data !== exp_v) begin
      $display("CHECK FAILED o_rdata: expected %h, got %h", exp_v, data);
      n_errs++;
    end
  endtask

  task automatic check_low(input string name, input logic val, input string when);
    if (val !== 1'b0) begin
      $display("CHECK FAILED %s %s: expected %h, got %h", name, when, 1'b0, val);
      n_errs++;
    end
  endtask

  task automatic check_reset_outputs(input string when);
    check_low("o_de", o_de, when);
    check_low("o_hs", o_hs, when);
    check_low("o_vs", o_vs, when);
    check_low("o_frame_done", o_frame_done, when);
    check_low("o_bvalid", o_bvalid, when);
    check_low("o_rvalid", o_rvalid, when);
    check_low("o_awready", o_awready, when);
    check_low("o_wready", o_wready, when);
    check_low("o_arready", o_arready, when);
    if (o_data !== '0) begin
      $display("CHECK FAILED o_data: expected %h, got %h", 24'h0, o_data);
      n_errs++;
    end
  endtask

  // mode 0 gives low codes, 1 codes near mid scale, 2 the full range
  task automatic load_samples(input int mode);
    for (int i = 0; i < WIN_W; i++) begin
      if (mode == 0) samp_sh[i] = 8'(rand_bits(4));
      else if (mode == 1) samp_sh[i] = 8'(112 + rand_bits(5));
      else samp_sh[i] = 8'(rand_bits(8));
    end
    for (int i = 0; i < WIN_W; i++) begin
      @(posedge i_ad_clk);
      i_ad_wr   <= 1'b1;
      i_ad_addr <= ADDR_W'(i);
      i_ad_data <= samp_sh[i];
    end
    @(posedge i_ad_clk);
    i_ad_wr <= 1'b0;
    repeat (4) @(posedge pclk);
  endtask

  task automatic run_frame();
    int fd_start;
    fd_start = fd_cnt;
    for (int row = 0; row < V_TOTAL; row++) begin
      for (int col = 0; col < H_TOTAL; col++) begin
        @(posedge pclk);
        i_de   <= (row < V_ACTIVE) && (col < H_ACTIVE);
        i_hs   <= (col >= 68) && (col < 72);
        i_vs   <= (row >= 42) && (row < 44);
        i_data <= rgb_t'(rand_bits(24));
        tb_x   <= col;
        tb_y   <= row;
      end
    end
    if (fd_cnt - fd_start != 1) begin
      $display("frame end pulse seen %0d times in one frame", fd_cnt - fd_start);
      n_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    if (n_errs == test_err_base) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: %0d errors", name, n_errs - test_err_base);
      tests_bad++;
    end
    test_err_base = n_errs;
  endtask

  initial begin : main_proc
    logic [31:0] data;
    logic [1:0]  resp;
    logic [3:0]  addr;
    logic [2:0]  gains [4];
    rst_n     = 1'b0;
    i_awaddr  = '0;
    i_awvalid = 1'b0;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_wvalid  = 1'b0;
    i_bready  = 1'b1;
    i_araddr  = '0;
    i_arvalid = 1'b0;
    i_rready  = 1'b1;
    i_ad_wr   = 1'b0;
    i_ad_addr = '0;
    i_ad_data = '0;
    i_hs      = 1'b0;
    i_vs      = 1'b0;
    i_de      = 1'b0;
    i_data    = '0;
    gains     = '{3'b001, 3'b010, 3'b101, 3'b110}; // right shift 1 and 2, then left shift

    repeat (4) @(posedge pclk);
    @(negedge pclk);
    check_reset_outputs("during reset");
    repeat (4) @(posedge pclk);
    rst_n <= 1'b1;
    @(negedge pclk);
    check_reset_outputs("just after reset");
    reg_check(REG_WAVE_COLOR, 32'h00ff_0000);
    reg_check(REG_TRIG_ROW, 32'h0);
    reg_check(REG_GAIN, 32'h0);
    finish_test("reset state");

    for (int r = 0; r < 3; r++) begin
      for (int k = 0; k < 4; k++) begin
        addr = 4'(r * 4);
        reg_write(addr, rand_bits(32), 4'(rand_bits(4)));
        reg_check(REG_WAVE_COLOR, sh_wave);
        reg_check(REG_TRIG_ROW, sh_trig);
        reg_check(REG_GAIN, sh_gain);
      end
    end
    reg_check(REG_ID, SCOPE_ID);
    axi_write(4'h6, rand_bits(32), 4'hf, resp); // hole in the map
    if (resp !== 2'b10) begin
      $display("CHECK FAILED o_bresp: expected %h, got %h", 2'b10, resp);
      n_errs++;
    end
    axi_read(4'he, data, resp);
    if (resp !== 2'b10) begin
      $display("CHECK FAILED o_rresp: expected %h, got %h", 2'b10, resp);
      n_errs++;
    end
    reg_check(REG_WAVE_COLOR, sh_wave);
    reg_check(REG_TRIG_ROW, sh_trig);
    reg_check(REG_GAIN, sh_gain);
    finish_test("register access");

    reg_write(REG_TRIG_ROW, 32'd100, 4'hf); // below the frame
    reg_write(REG_GAIN, 32'h7, 4'hf);       // trace pinned to the bottom row
    load_samples(0);
    run_frame();
    finish_test("pass-through");

    reg_write(REG_WAVE_COLOR, rand_bits(24), 4'hf);
    reg_write(REG_GAIN, 32'h0, 4'hf);
    load_samples(1);
    run_frame();
    finish_test("trace drawing");

    for (int g = 0; g < 4; g++) begin
      reg_write(REG_GAIN, 32'(gains[g]), 4'hf);
      load_samples(2);
      run_frame();
    end
    finish_test("gain");

    blue_cnt = 0;
    reg_write(REG_TRIG_ROW, 32'(WIN_Y0 + rand_bits(5)), 4'hf);
    reg_write(REG_GAIN, 32'h0, 4'hf);
    load_samples(1);
    run_frame();
    if (blue_cnt == 0) begin
      $display("trigger line was never drawn");
      n_errs++;
    end
    finish_test("trigger line and frame end");

    $display("tests ok: %0d, tests with errors: %0d, total errors: %0d",
             tests_ok, tests_bad, n_errs);
    if (n_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- flist.f
verilog/scope_pkg.sv
verilog/scope_if.sv
verilog/sample_ram.sv
verilog/scope_cfg_axil.sv
verilog/pixel_position.sv
verilog/wave_overlay.sv
verilog/scope_display_top.sv
test/tb_scope.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_scope \
  -Mdir obj_dir -o tb_scope
./obj_dir/tb_scope > sim.log 2>&1 || true
cat sim.log
if grep -qF '*** PASSED ***' sim.log; then
  exit 0
fi
exit 1
